/* Makefile */
# Verilator flow for the muldiv unit testbench

VERILATOR  ?= verilator
TOP        ?= muldiv_tb
RTL_TOP    ?= muldiv_unit
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --timing --assert
FAIL_TEXT  ?= Verification failed
PASS_TEXT  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/muldiv_ifs.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Internal links between the stages, each a val/rdy channel
// Payload must hold steady while val is high and rdy is low
// ----------------------------------------------------------------------

// Issue stage to iteration core
interface muldiv_req_if #(
  parameter int seq_num_bits = 5
);
  import muldiv_pkg::*;

  logic                    val;
  logic                    rdy;
  // Operand magnitudes, signs already stripped
  word_t                   mag_a;
  word_t                   mag_b;
  logic                    is_div;
  // Final result must be negated
  logic                    neg_result;
  // High product word or remainder wanted
  logic                    take_hi_or_rem;
  word_t                   pc;
  logic [seq_num_bits-1:0] seq_num;
  raddr_t                  waddr;

  modport source (output val, mag_a, mag_b, is_div, neg_result, take_hi_or_rem,
                  pc, seq_num, waddr, input rdy);
  modport sink   (input val, mag_a, mag_b, is_div, neg_result, take_hi_or_rem,
                  pc, seq_num, waddr, output rdy);
endinterface

// Iteration core to writeback stage
interface muldiv_rsp_if #(
  parameter int seq_num_bits = 5
);
  import muldiv_pkg::*;

  logic                    val;
  logic                    rdy;
  // Unsigned product, or {remainder, quotient}
  dword_t                  raw;
  logic                    is_div;
  logic                    neg_result;
  logic                    take_hi_or_rem;
  word_t                   pc;
  logic [seq_num_bits-1:0] seq_num;
  raddr_t                  waddr;

  modport source (output val, raw, is_div, neg_result, take_hi_or_rem,
                  pc, seq_num, waddr, input rdy);
  modport sink   (input val, raw, is_div, neg_result, take_hi_or_rem,
                  pc, seq_num, waddr, output rdy);
endinterface

/* design/muldiv_issue.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Input stage, holds one decoded request for the core
// d_rdy never looks at d_val in the same cycle
// ----------------------------------------------------------------------

module muldiv_issue #(
  parameter int seq_num_bits = 5
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    d_val,
  output logic                    d_rdy,
  input  muldiv_pkg::word_t       d_pc,
  input  logic [seq_num_bits-1:0] d_seq_num,
  input  muldiv_pkg::word_t       d_op1,
  input  muldiv_pkg::word_t       d_op2,
  input  muldiv_pkg::raddr_t      d_waddr,
  input  muldiv_pkg::muldiv_op_e  d_uop,
  muldiv_req_if.source            req
);
  import muldiv_pkg::*;

  logic  signed_a;
  logic  signed_b;
  logic  sign_a;
  logic  sign_b;
  logic  is_div;
  logic  take_hi;
  logic  neg_result;
  word_t mag_a;
  word_t mag_b;

  // ----------------------------------------------------------------------
  // Uop decode
  // ----------------------------------------------------------------------

  assign is_div   = d_uop inside {op_div, op_divu, op_rem, op_remu};
  assign take_hi  = d_uop inside {op_mulh, op_mulhsu, op_mulhu, op_rem, op_remu};
  // mulhsu keeps op2 unsigned
  assign signed_a = d_uop inside {op_mul, op_mulh, op_mulhsu, op_div, op_rem};
  assign signed_b = d_uop inside {op_mul, op_mulh, op_div, op_rem};

  // Effective operand signs
  assign sign_a = signed_a & d_op1[31];
  assign sign_b = signed_b & d_op2[31];

  // Magnitudes; min value maps onto itself, still right as unsigned
  assign mag_a = sign_a ? -d_op1 : d_op1;
  assign mag_b = sign_b ? -d_op2 : d_op2;

  always_comb begin
    if (!is_div) begin
      neg_result = sign_a ^ sign_b;
    end else if (take_hi) begin
      // Remainder follows the dividend
      neg_result = sign_a;
    end else begin
      // Divide by zero keeps the all-ones quotient
      neg_result = (sign_a ^ sign_b) & (d_op2 != '0);
    end
  end

  // ----------------------------------------------------------------------
  // Holding register
  // ----------------------------------------------------------------------

  // Free, or emptying into the core this cycle
  assign d_rdy = !req.val || req.rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req.val <= 1'b0;
    end else if (d_rdy) begin
      req.val <= d_val;
    end
  end

  always_ff @(posedge clk) begin
    if (d_val && d_rdy) begin
      req.mag_a          <= mag_a;
      req.mag_b          <= mag_b;
      req.is_div         <= is_div;
      req.neg_result     <= neg_result;
      req.take_hi_or_rem <= take_hi;
      req.pc             <= d_pc;
      req.seq_num        <= d_seq_num;
      req.waddr          <= d_waddr;
    end
  end

endmodule

/* design/muldiv_iter_core.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Shared radix-2 core, num_iter cycles per op, no early termination
// Unsigned only; signs are handled by the stages around it
// ----------------------------------------------------------------------

module muldiv_iter_core #(
  parameter int seq_num_bits = 5
) (
  input  logic         clk,
  input  logic         rst_n,
  muldiv_req_if.sink   req,
  muldiv_rsp_if.source rsp
);
  import muldiv_pkg::*;

  localparam int cnt_bits = $clog2(num_iter);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } state_e;

  state_e              state;
  logic [cnt_bits-1:0] iter_cnt;
  logic                last_iter;
  // Working register, final value goes out as rsp.raw
  dword_t              acc;
  // Multiplicand or divisor
  word_t               opb;
  logic [32:0]         mul_sum;
  logic [32:0]         part_rem;
  logic [33:0]         trial;
  dword_t              acc_next;

  // Ready only when idle, so never a function of req.val
  assign req.rdy   = (state == st_idle);
  assign rsp.val   = (state == st_done);
  assign rsp.raw   = acc;
  assign last_iter = (iter_cnt == cnt_bits'(num_iter - 1));

  // ----------------------------------------------------------------------
  // One iteration step
  // ----------------------------------------------------------------------

  always_comb begin
    // Multiply: add opb under the current multiplier bit, shift right
    mul_sum  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, opb} : 33'd0);
    // Divide: remainder shifted left, next dividend bit pulled in
    part_rem = acc[63:31];
    trial    = {1'b0, part_rem} - {2'b00, opb};
    if (rsp.is_div) begin
      if (trial[33]) begin
        // Restore, quotient bit 0
        acc_next = {part_rem[31:0], acc[30:0], 1'b0};
      end else begin
        acc_next = {trial[31:0], acc[30:0], 1'b1};
      end
    end else begin
      acc_next = {mul_sum, acc[31:1]};
    end
  end

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      iter_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          iter_cnt <= '0;
          if (req.val) begin
            state <= st_run;
          end
        end
        st_run: begin
          iter_cnt <= iter_cnt + 1'b1;
          if (last_iter) begin
            state <= st_done;
          end
        end
        st_done: begin
          // Result held until writeback takes it
          if (rsp.rdy) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Datapath and tags
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (req.val && req.rdy) begin
      // Multiplier or dividend starts in the low half
      acc                <= {32'd0, req.mag_a};
      opb                <= req.mag_b;
      rsp.is_div         <= req.is_div;
      rsp.neg_result     <= req.neg_result;
      rsp.take_hi_or_rem <= req.take_hi_or_rem;
      rsp.pc             <= req.pc;
      rsp.seq_num        <= req.seq_num;
      rsp.waddr          <= req.waddr;
    end else if (state == st_run) begin
      acc <= acc_next;
    end
  end

endmodule

/* design/muldiv_pkg.sv */
// ----------------------------------------------------------------------
// Shared types and constants for the iterative M-extension unit
// Enum order follows the RISC-V funct3 encoding of the M-extension
// ----------------------------------------------------------------------

package muldiv_pkg;

  // ----------------------------------------------------------------------
  // Data widths
  // ----------------------------------------------------------------------

  // Operand and result word
  typedef logic [31:0] word_t;

  // Full product, or remainder in hi and quotient in lo
  typedef logic [63:0] dword_t;

  // Architectural register address
  typedef logic [4:0]  raddr_t;

  // ----------------------------------------------------------------------
  // Micro-ops
  // ----------------------------------------------------------------------

  // Bit 2 set for the divide family
  typedef enum logic [2:0] {
    op_mul    = 3'd0,
    op_mulh   = 3'd1,
    op_mulhsu = 3'd2,
    op_mulhu  = 3'd3,
    op_div    = 3'd4,
    op_divu   = 3'd5,
    op_rem    = 3'd6,
    op_remu   = 3'd7
  } muldiv_op_e;

  // ----------------------------------------------------------------------
  // Timing constants
  // ----------------------------------------------------------------------

  // One iteration per operand bit, no early exit
  localparam int num_iter = 32;

  // Idle unit, D handshake edge to w_val high
  // Issue reg + iterations + writeback reg
  localparam int muldiv_latency = 34;

endpackage

/* design/muldiv_unit.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Top of the M-extension unit, up to three ops in flight
// ----------------------------------------------------------------------

module muldiv_unit #(
  parameter int seq_num_bits = 5
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // Decode side
  input  logic                    d_val,
  output logic                    d_rdy,
  input  muldiv_pkg::word_t       d_pc,
  input  logic [seq_num_bits-1:0] d_seq_num,
  input  muldiv_pkg::word_t       d_op1,
  input  muldiv_pkg::word_t       d_op2,
  input  muldiv_pkg::raddr_t      d_waddr,
  input  muldiv_pkg::muldiv_op_e  d_uop,
  // Writeback side
  output logic                    w_val,
  input  logic                    w_rdy,
  output muldiv_pkg::word_t       w_pc,
  output logic [seq_num_bits-1:0] w_seq_num,
  output muldiv_pkg::raddr_t      w_waddr,
  output muldiv_pkg::word_t       w_wdata,
  output logic                    w_wen
);

  // Stage links
  muldiv_req_if #(.seq_num_bits(seq_num_bits)) req ();
  muldiv_rsp_if #(.seq_num_bits(seq_num_bits)) rsp ();

  muldiv_issue #(.seq_num_bits(seq_num_bits)) u_issue (
    .clk       (clk),
    .rst_n     (rst_n),
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_pc      (d_pc),
    .d_seq_num (d_seq_num),
    .d_op1     (d_op1),
    .d_op2     (d_op2),
    .d_waddr   (d_waddr),
    .d_uop     (d_uop),
    .req       (req.source)
  );

  muldiv_iter_core #(.seq_num_bits(seq_num_bits)) u_core (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req.sink),
    .rsp   (rsp.source)
  );

  muldiv_writeback #(.seq_num_bits(seq_num_bits)) u_writeback (
    .clk       (clk),
    .rst_n     (rst_n),
    .rsp       (rsp.sink),
    .w_val     (w_val),
    .w_rdy     (w_rdy),
    .w_pc      (w_pc),
    .w_seq_num (w_seq_num),
    .w_waddr   (w_waddr),
    .w_wdata   (w_wdata),
    .w_wen     (w_wen)
  );

endmodule

/* design/muldiv_writeback.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Output stage, sign fix-up and result select into one W register
// Holds w_val and data steady while w_rdy is low
// ----------------------------------------------------------------------

module muldiv_writeback #(
  parameter int seq_num_bits = 5
) (
  input  logic                    clk,
  input  logic                    rst_n,
  muldiv_rsp_if.sink              rsp,
  output logic                    w_val,
  input  logic                    w_rdy,
  output muldiv_pkg::word_t       w_pc,
  output logic [seq_num_bits-1:0] w_seq_num,
  output muldiv_pkg::raddr_t      w_waddr,
  output muldiv_pkg::word_t       w_wdata,
  output logic                    w_wen
);
  import muldiv_pkg::*;

  dword_t prod_fix;
  word_t  half;
  word_t  result;

  // ----------------------------------------------------------------------
  // Sign correction and result select
  // ----------------------------------------------------------------------

  // Multiply negates the whole product, borrow reaches the high word
  assign prod_fix = rsp.neg_result ? -rsp.raw : rsp.raw;
  // Divide picks remainder or quotient first
  assign half     = rsp.take_hi_or_rem ? rsp.raw[63:32] : rsp.raw[31:0];

  always_comb begin
    if (rsp.is_div) begin
      // Only the chosen word is negated
      result = rsp.neg_result ? -half : half;
    end else if (rsp.take_hi_or_rem) begin
      result = prod_fix[63:32];
    end else begin
      result = prod_fix[31:0];
    end
  end

  // ----------------------------------------------------------------------
  // W register
  // ----------------------------------------------------------------------

  // Empty, or draining to W this cycle
  assign rsp.rdy = !w_val || w_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      w_val <= 1'b0;
    end else if (rsp.rdy) begin
      w_val <= rsp.val;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp.val && rsp.rdy) begin
      w_pc      <= rsp.pc;
      w_seq_num <= rsp.seq_num;
      w_waddr   <= rsp.waddr;
      w_wdata   <= result;
      // x0 is never written
      w_wen     <= (rsp.waddr != '0);
    end
  end

endmodule

/* tb.f */
+incdir+verif
design/muldiv_pkg.sv
design/muldiv_ifs.sv
design/muldiv_issue.sv
design/muldiv_iter_core.sv
design/muldiv_writeback.sv
design/muldiv_unit.sv
verif/muldiv_tb.sv

/* verif/muldiv_ref.svh */
// ----------------------------------------------------------------------
// Golden model of the eight M-extension results, one word per call
// Needs muldiv_pkg imported into the including scope
// ----------------------------------------------------------------------

`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

// Expected rd value for one operation, per the RISC-V M-extension rules
function automatic word_t ref_result(input muldiv_op_e op, input word_t a, input word_t b);
  dword_t             sa;
  dword_t             sb;
  dword_t             ua;
  dword_t             ub;
  dword_t             prod;
  logic               ovf;
  logic signed [31:0] sdiv_a;
  logic signed [31:0] sdiv_b;
  logic signed [31:0] squot;
  logic signed [31:0] srem;
  word_t              res;
  // Sign and zero extended operands, low 64 bits of any product are exact
  sa     = {{32{a[31]}}, a};
  sb     = {{32{b[31]}}, b};
  ua     = {32'd0, a};
  ub     = {32'd0, b};
  ovf    = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  sdiv_a = a;
  sdiv_b = b;
  squot  = '0;
  srem   = '0;
  // Signed divide only where it is defined
  if (b != '0 && !ovf) begin
    squot = sdiv_a / sdiv_b;
    srem  = sdiv_a % sdiv_b;
  end
  case (op)
    op_mulh:   prod = sa * sb;
    op_mulhsu: prod = sa * ub;
    default:   prod = ua * ub;
  endcase
  case (op)
    op_mul:    res = prod[31:0];
    op_mulh,
    op_mulhsu,
    op_mulhu:  res = prod[63:32];
    // Zero divisor gives all ones, overflow keeps the dividend
    op_div:    res = (b == '0) ? '1 : (ovf ? a : squot);
    op_divu:   res = (b == '0) ? '1 : a / b;
    // Zero divisor returns the dividend, overflow leaves nothing
    op_rem:    res = (b == '0) ? a : (ovf ? '0 : srem);
    default:   res = (b == '0) ? a : a % b;
  endcase
  return res;
endfunction

`endif

/* verif/muldiv_tb.sv */
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Self-checking bench for muldiv_unit, corner grid then random stress
// Expected results come from the golden model, checked in issue order
// ----------------------------------------------------------------------

module muldiv_tb;
  import muldiv_pkg::*;
  `include "muldiv_ref.svh"

  localparam int seq_num_bits = 5;
  // 5 x 5 corner pairs per uop, random ops, one latency probe
  localparam int num_corner   = 200;
  localparam int num_rand     = 300;
  localparam int num_ops      = num_corner + num_rand + 1;

  typedef struct packed {
    word_t                   pc;
    logic [seq_num_bits-1:0] seq;
    raddr_t                  waddr;
    logic                    wen;
    word_t                   wdata;
  } exp_t;

  logic clk;
  logic rst_n;
  logic d_val;
  logic d_rdy;
  word_t d_pc;
  logic [seq_num_bits-1:0] d_seq_num;
  word_t d_op1;
  word_t d_op2;
  raddr_t d_waddr;
  muldiv_op_e d_uop;
  logic w_val;
  logic w_rdy;
  word_t w_pc;
  logic [seq_num_bits-1:0] w_seq_num;
  raddr_t w_waddr;
  word_t w_wdata;
  logic w_wen;

  integer seed = 32'haf85445f;
  integer rdy_seed;
  logic   stress;
  int     op_cnt;
  int     n_issued;
  int     n_retired;
  string  test_name;
  exp_t   exp_q[$];
  word_t  corners[5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

  muldiv_unit #(.seq_num_bits(seq_num_bits)) DUT (
    .clk(clk), .rst_n(rst_n),
    .d_val(d_val), .d_rdy(d_rdy), .d_pc(d_pc), .d_seq_num(d_seq_num),
    .d_op1(d_op1), .d_op2(d_op2), .d_waddr(d_waddr), .d_uop(d_uop),
    .w_val(w_val), .w_rdy(w_rdy), .w_pc(w_pc), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_wdata(w_wdata), .w_wen(w_wen)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Failure reporting
  // ----------------------------------------------------------------------

  task automatic end_with_failure();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic show_mismatch(input string what, input word_t exp, input word_t act);
    $display("ERROR %s %s expected %h actual %h", test_name, what, exp, act);
    end_with_failure();
  endtask

  task automatic raise_problem(input string msg);
    $display("%s during %s", msg, test_name);
    end_with_failure();
  endtask

  // ----------------------------------------------------------------------
  // Stimulus helpers, always entered on a rising edge
  // ----------------------------------------------------------------------

  // Holds d_val until the handshake edge, d_val left high for back-to-back
  task automatic send_op(input muldiv_op_e op, input word_t a, input word_t b,
                         input raddr_t wa);
    d_val     <= 1'b1;
    d_uop     <= op;
    d_op1     <= a;
    d_op2     <= b;
    d_waddr   <= wa;
    d_pc      <= 32'h0000_1000 + word_t'(op_cnt << 2);
    d_seq_num <= op_cnt[seq_num_bits-1:0];
    op_cnt++;
    @(posedge clk);
    while (!d_rdy) @(posedge clk);
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0 || w_val) @(posedge clk);
  endtask

  // Corner value one time in four, otherwise a full random word
  function automatic word_t pick_operand();
    word_t r;
    r = $random(seed);
    if (r[1:0] == 2'b00) begin
      return corners[int'(r[7:2]) % 5];
    end
    return $random(seed);
  endfunction

  // Random back-pressure only in the stress phase
  always @(posedge clk) begin
    logic [31:0] rnd;
    rnd = $random(rdy_seed);
    w_rdy <= stress ? (rnd[1:0] != 2'b00) : 1'b1;
  end

  // ----------------------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    exp_t e;
    if (rst_n && d_val && d_rdy) begin
      e.pc    = d_pc;
      e.seq   = d_seq_num;
      e.waddr = d_waddr;
      e.wen   = (d_waddr != '0);
      e.wdata = ref_result(d_uop, d_op1, d_op2);
      exp_q.push_back(e);
      n_issued++;
    end
  end

  always @(posedge clk) begin
    exp_t e;
    if (rst_n && w_val && w_rdy) begin
      assert (exp_q.size() != 0) else raise_problem("Result returned with nothing in flight");
      e = exp_q.pop_front();
      n_retired++;
      assert (w_wdata == e.wdata) else show_mismatch("wdata", e.wdata, w_wdata);
      assert (w_pc == e.pc) else show_mismatch("pc", e.pc, w_pc);
      assert (w_seq_num == e.seq) else show_mismatch("seq_num", word_t'(e.seq), word_t'(w_seq_num));
      assert (w_waddr == e.waddr) else show_mismatch("waddr", word_t'(e.waddr), word_t'(w_waddr));
      assert (w_wen == e.wen) else show_mismatch("wen", word_t'(e.wen), word_t'(w_wen));
    end
  end

  // Stalled W output must not move
  assert property (@(posedge clk) disable iff (!rst_n)
    (w_val && !w_rdy) |=> (w_val && $stable(w_wdata) && $stable(w_pc) &&
      $stable(w_seq_num) && $stable(w_waddr) && $stable(w_wen)))
    else raise_problem("W output changed while w_rdy was low");

  // Worst case is well under 40 cycles per op
  initial begin
    repeat (num_ops * 40 + 500) @(posedge clk);
    $display("Timeout, the unit stopped returning results");
    end_with_failure();
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    int lat;
    logic [31:0] rnd;
    d_val     = 1'b0;
    d_pc      = '0;
    d_seq_num = '0;
    d_op1     = '0;
    d_op2     = '0;
    d_waddr   = '0;
    d_uop     = op_mul;
    w_rdy     = 1'b1;
    stress    = 1'b0;
    op_cnt    = 0;
    n_issued  = 0;
    n_retired = 0;
    rdy_seed  = $random(seed);
    test_name = "reset";
    rst_n     = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!w_val) else show_mismatch("w_val", 32'd0, word_t'(w_val));
    assert (d_rdy) else show_mismatch("d_rdy", 32'd1, word_t'(d_rdy));

    // Every uop over the corner grid, waddr sweeps through 0
    test_name = "corner";
    for (int k = 0; k < 8; k++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          send_op(muldiv_op_e'(k), corners[i], corners[j], raddr_t'(op_cnt));
        end
      end
    end
    d_val <= 1'b0;
    wait_drained();

    // Continuous d_val against random w_rdy
    test_name = "stress";
    stress    = 1'b1;
    for (int i = 0; i < num_rand; i++) begin
      rnd = $random(seed);
      send_op(muldiv_op_e'(rnd[2:0]), pick_operand(), pick_operand(), raddr_t'(rnd[9:5]));
    end
    d_val  <= 1'b0;
    wait_drained();
    stress = 1'b0;
    repeat (2) @(posedge clk);

    // Idle unit, count edges from the D handshake to w_val
    test_name = "latency";
    send_op(op_divu, 32'd1000, 32'd7, 5'd3);
    d_val <= 1'b0;
    lat = 0;
    while (!w_val) begin
      @(posedge clk);
      lat++;
    end
    assert (lat - 1 == muldiv_latency)
      else show_mismatch("cycles", word_t'(muldiv_latency), word_t'(lat - 1));
    wait_drained();

    repeat (5) @(posedge clk);
    if (exp_q.size() == 0 && n_retired == n_issued && n_issued == num_ops) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Run ended with %0d issued and %0d retired", n_issued, n_retired);
      end_with_failure();
    end
  end

endmodule
